// ==== src.f ====
+incdir+verification
src/ahb_mem_pkg.sv
src/ahb_decoder.sv
src/ahb_ram.sv
src/ahb_ram_cfg.sv
src/ahb_mem_top.sv
verification/tb_ahb_mem.sv

// ==== Makefile ====
# Verilator build and run for the protected AHB memory subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module tb_ahb_mem -f src.f -o Vtb_ahb_mem

run: build
	./obj_dir/Vtb_ahb_mem

lint:
	verilator --lint-only --timing -Wall --top-module tb_ahb_mem -f src.f
	verilator --lint-only -Wall --top-module ahb_mem_top \
		src/ahb_mem_pkg.sv src/ahb_decoder.sv src/ahb_ram.sv \
		src/ahb_ram_cfg.sv src/ahb_mem_top.sv

clean:
	rm -rf obj_dir

// ==== verification/tb_ahb_mem_model.svh ====
// Reference model of the protected RAM
// Word and checksum arrays plus byte-lane, parity and response rules

ahb_mem_pkg::data_t model_mem  [ahb_mem_pkg::MEM_WORDS];
ahb_mem_pkg::csum_t model_csum [ahb_mem_pkg::MEM_WORDS];

// A byte lane is written when it lies in the same size-aligned block as the address
function automatic logic [3:0] lane_mask(ahb_mem_pkg::hsize_e size, logic [1:0] ofs);
    logic [3:0] mask;
    for (int b = 0; b < 4; b++) begin
        mask[b] = ((b >> int'(size)) == (int'(ofs) >> int'(size)));
    end
    return mask;
endfunction

function automatic ahb_mem_pkg::data_t merge_word(ahb_mem_pkg::data_t old_word,
                                                  ahb_mem_pkg::data_t wdata,
                                                  logic [3:0] mask);
    ahb_mem_pkg::data_t res;
    for (int b = 0; b < 4; b++) begin
        res[8*b +: 8] = mask[b] ? wdata[8*b +: 8] : old_word[8*b +: 8];
    end
    return res;
endfunction

// Even parity per field group
function automatic ahb_mem_pkg::par_t bus_parity(ahb_mem_pkg::ahb_req_t r);
    ahb_mem_pkg::par_t p;
    p[0] = ^r.haddr[7:0];
    p[1] = ^r.haddr[15:8];
    p[2] = ^r.haddr[23:16];
    p[3] = ^r.haddr[31:24];
    p[4] = ^{r.hsize, r.hburst, r.hprot, r.hwrite, r.hmastlock};
    p[5] = ^r.htrans;
    return p;
endfunction

function automatic void model_write(ahb_mem_pkg::addr_t addr, ahb_mem_pkg::hsize_e size,
                                    ahb_mem_pkg::data_t wdata, ahb_mem_pkg::csum_t csum);
    int idx;
    idx = int'(addr[11:2]);
    model_mem[idx]  = merge_word(model_mem[idx], wdata, lane_mask(size, addr[1:0]));
    model_csum[idx] = csum;
endfunction

// Error transfers take one low cycle, RAM transfers take the programmed count
function automatic ahb_mem_pkg::wait_t expect_lows(logic err, logic is_ram,
                                                   ahb_mem_pkg::wait_t waits);
    if (err) begin
        return 2'd1;
    end
    return is_ram ? waits : 2'd0;
endfunction

// ==== verification/tb_ahb_mem.sv ====
// Testbench for the protected AHB3-Lite memory subsystem
// Scoreboard of expected data phases checked against the bus response

module tb_ahb_mem;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int NUM_WORDS      = 32;
    localparam int K_NONE         = 0;
    localparam int K_RAM          = 1;
    localparam int K_WAIT         = 2;
    localparam int K_CNT          = 3;

    logic                   s_clk_i = 1'b0;
    logic                   s_resetn_i;
    ahb_mem_pkg::ahb_req_t  req_i;
    ahb_mem_pkg::ahb_wdat_t wdat_i;
    ahb_mem_pkg::ahb_rsp_t  rsp_o;

    `include "tb_ahb_mem_model.svh"

    // Expected data phases, in acceptance order
    int                   exp_kind [$];
    ahb_mem_pkg::data_t   exp_data [$];
    ahb_mem_pkg::csum_t   exp_csum [$];
    logic                 exp_resp [$];
    ahb_mem_pkg::wait_t   exp_lows [$];

    string                test_name;
    logic [31:0]          lcg_state = 32'hf330;
    ahb_mem_pkg::wait_t   cur_wait;
    ahb_mem_pkg::errcnt_t exp_errcnt;
    int                   cycles;
    logic                 dp_busy;
    ahb_mem_pkg::wait_t   lows;
    ahb_mem_pkg::addr_t   err_addr [6];

    ahb_mem_top dut0 (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .req_i      (req_i),
        .wdat_i     (wdat_i),
        .rsp_o      (rsp_o)
    );

    always #2 s_clk_i = ~s_clk_i;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task report_fail();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_data(string name, ahb_mem_pkg::data_t exp, ahb_mem_pkg::data_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_csum(string name, ahb_mem_pkg::csum_t exp, ahb_mem_pkg::csum_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_resp(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_wait(string name, ahb_mem_pkg::wait_t exp, ahb_mem_pkg::wait_t act);
        if (exp !== act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            report_fail();
        end
    endtask

    task automatic check_count(string name, ahb_mem_pkg::errcnt_t exp,
                               ahb_mem_pkg::errcnt_t act);
        if (exp !== act) begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            report_fail();
        end
    endtask

    // Drive one address phase, record its expectation, return once accepted
    task automatic addr_phase(ahb_mem_pkg::addr_t addr, logic write, ahb_mem_pkg::hsize_e size,
                              ahb_mem_pkg::data_t wdata, ahb_mem_pkg::csum_t csum, int flip);
        ahb_mem_pkg::ahb_req_t r;
        logic is_ram;
        logic is_cfg;
        logic err;
        int   kind;
        int   idx;
        ahb_mem_pkg::data_t ed;
        ahb_mem_pkg::csum_t ec;
        r.haddr     = addr;
        r.htrans    = ahb_mem_pkg::NONSEQ;
        r.hwrite    = write;
        r.hsize     = size;
        r.hburst    = 3'b000;
        r.hprot     = 4'b0011;
        r.hmastlock = 1'b0;
        r.hparity   = bus_parity(r);
        if (flip >= 0) begin
            r.hparity[flip] = ~r.hparity[flip];
        end
        is_ram = ((addr & ahb_mem_pkg::REGION_MASK) == ahb_mem_pkg::RAM_BASE);
        is_cfg = ((addr & ahb_mem_pkg::REGION_MASK) == ahb_mem_pkg::CFG_BASE);
        err    = (is_ram && flip >= 0) || (!is_ram && !is_cfg);
        idx    = int'(addr[11:2]);
        kind   = K_NONE;
        ed     = '0;
        ec     = '0;
        if (is_ram && flip >= 0 && exp_errcnt != '1) begin
            exp_errcnt = exp_errcnt + 1'b1;
        end
        exp_lows.push_back(expect_lows(err, is_ram, cur_wait));
        if (!err && is_ram && write) begin
            model_write(addr, size, wdata, csum);
        end else if (!err && is_ram) begin
            kind = K_RAM;
            ed   = model_mem[idx];
            ec   = model_csum[idx];
        end else if (is_cfg && !write) begin
            kind = addr[2] ? K_CNT : K_WAIT;
            ed   = addr[2] ? {16'h0, exp_errcnt} : {30'h0, cur_wait};
        end else if (is_cfg) begin
            if (addr[2]) begin
                exp_errcnt = '0;
            end else begin
                cur_wait = wdata[1:0];
            end
        end
        exp_kind.push_back(kind);
        exp_data.push_back(ed);
        exp_csum.push_back(ec);
        exp_resp.push_back(err);
        req_i = r;
        do @(negedge s_clk_i); while (!rsp_o.hready);
        @(posedge s_clk_i);
        #1;
        wdat_i.hwdata     = wdata;
        wdat_i.hwchecksum = csum;
        req_i.htrans      = ahb_mem_pkg::IDLE;
    endtask

    // Let the pending data phase finish with the bus idle
    task automatic idle_cycle();
        req_i.htrans = ahb_mem_pkg::IDLE;
        do @(negedge s_clk_i); while (!rsp_o.hready);
        @(posedge s_clk_i);
        #1;
    endtask

    task automatic single_xfer(ahb_mem_pkg::addr_t addr, logic write, ahb_mem_pkg::hsize_e size,
                               ahb_mem_pkg::data_t wdata, ahb_mem_pkg::csum_t csum, int flip);
        addr_phase(addr, write, size, wdata, csum, flip);
        idle_cycle();
    endtask

    function ahb_mem_pkg::hsize_e rand_size();
        logic [31:0] r;
        r = lcg_next() % 3;
        return (r == 0) ? ahb_mem_pkg::BYTE : (r == 1) ? ahb_mem_pkg::HALF : ahb_mem_pkg::WORD;
    endfunction

    // Offset aligned to the transfer size
    function ahb_mem_pkg::addr_t rand_addr(ahb_mem_pkg::hsize_e size);
        logic [31:0] r;
        logic [1:0]  ofs;
        r   = lcg_next();
        ofs = (size == ahb_mem_pkg::BYTE) ? r[9:8] :
              (size == ahb_mem_pkg::HALF) ? {r[9], 1'b0} : 2'b00;
        return {25'h0, 5'(r[20:16] % NUM_WORDS), ofs};
    endfunction

    task automatic random_write();
        ahb_mem_pkg::hsize_e sz;
        sz = rand_size();
        single_xfer(rand_addr(sz), 1'b1, sz, lcg_next(), 7'(lcg_next() >> 9), -1);
    endtask

    // Comparing process, sampled mid-cycle where the bus is stable
    always @(negedge s_clk_i) begin
        if (s_resetn_i) begin
            if (dp_busy && !rsp_o.hready) begin
                lows = lows + 1'b1;
            end else if (dp_busy) begin
                if (exp_kind.size() == 0) begin
                    $display("A data phase completed with no transfer expected");
                    report_fail();
                end
                check_resp({test_name, " hresp"}, exp_resp[0], rsp_o.hresp);
                check_wait({test_name, " wait cycles"}, exp_lows[0], lows);
                case (exp_kind[0])
                    K_RAM: begin
                        check_data({test_name, " data"}, exp_data[0], rsp_o.hrdata);
                        check_csum({test_name, " checksum"}, exp_csum[0], rsp_o.hrchecksum);
                    end
                    K_WAIT: check_wait({test_name, " wait reg"}, exp_data[0][1:0],
                                       rsp_o.hrdata[1:0]);
                    K_CNT:  check_count({test_name, " err count"}, exp_data[0][15:0],
                                        rsp_o.hrdata[15:0]);
                    default: ;
                endcase
                void'(exp_kind.pop_front());
                void'(exp_data.pop_front());
                void'(exp_csum.pop_front());
                void'(exp_resp.pop_front());
                void'(exp_lows.pop_front());
                dp_busy = 1'b0;
            end
            if (rsp_o.hready && (req_i.htrans == ahb_mem_pkg::NONSEQ ||
                                 req_i.htrans == ahb_mem_pkg::SEQ)) begin
                dp_busy = 1'b1;
                lows    = '0;
            end
        end
    end

    always @(posedge s_clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_fail();
        end
    end

    initial begin
        req_i      = '0;
        wdat_i     = '0;
        s_resetn_i = 1'b0;
        cur_wait   = '0;
        exp_errcnt = '0;
        dp_busy    = 1'b0;
        lows       = '0;
        cycles     = 0;
        repeat (8) @(posedge s_clk_i);
        #1;
        s_resetn_i = 1'b1;

        test_name = "reset";
        @(negedge s_clk_i);
        check_resp("reset hready", 1'b1, rsp_o.hready);
        check_resp("reset hresp", 1'b0, rsp_o.hresp);
        @(posedge s_clk_i);
        #1;
        single_xfer(ahb_mem_pkg::CFG_BASE, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
        single_xfer(ahb_mem_pkg::CFG_BASE + 4, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);

        test_name = "random rw";
        for (int i = 0; i < NUM_WORDS; i++) begin
            single_xfer(32'(i * 4), 1'b1, ahb_mem_pkg::WORD, lcg_next(), 7'(lcg_next()), -1);
        end
        for (int i = 0; i < 150; i++) begin
            random_write();
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            single_xfer(32'(i * 4), 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
        end

        test_name = "forwarding";
        for (int i = 0; i < 16; i++) begin
            ahb_mem_pkg::hsize_e sz;
            ahb_mem_pkg::addr_t  a;
            sz = rand_size();
            a  = rand_addr(sz);
            addr_phase(a, 1'b1, sz, lcg_next(), 7'(lcg_next()), -1);
            addr_phase({a[31:2], 2'b00}, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
            idle_cycle();
        end

        test_name = "parity error";
        for (int b = 0; b < 6; b++) begin
            err_addr[b] = rand_addr(ahb_mem_pkg::WORD);
            single_xfer(err_addr[b], 1'b1, ahb_mem_pkg::WORD, lcg_next(), 7'(lcg_next()), b);
        end
        for (int b = 0; b < 6; b++) begin
            single_xfer(err_addr[b], 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
        end
        single_xfer(ahb_mem_pkg::CFG_BASE + 4, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
        single_xfer(ahb_mem_pkg::CFG_BASE + 4, 1'b1, ahb_mem_pkg::WORD, 32'h1, '0, -1);
        single_xfer(ahb_mem_pkg::CFG_BASE + 4, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);

        test_name = "unmapped";
        single_xfer(32'h0002_0000, 1'b1, ahb_mem_pkg::WORD, lcg_next(), '0, -1);
        req_i.haddr = 32'h0002_0000;
        repeat (2) begin
            @(negedge s_clk_i);
            check_resp("idle unmapped hready", 1'b1, rsp_o.hready);
            check_resp("idle unmapped hresp", 1'b0, rsp_o.hresp);
        end
        @(posedge s_clk_i);
        #1;

        test_name = "wait states";
        for (int w = 0; w < 4; w++) begin
            single_xfer(ahb_mem_pkg::CFG_BASE, 1'b1, ahb_mem_pkg::WORD, 32'(w), '0, -1);
            single_xfer(ahb_mem_pkg::CFG_BASE, 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
            for (int i = 0; i < 3; i++) begin
                random_write();
                single_xfer(rand_addr(ahb_mem_pkg::WORD), 1'b0, ahb_mem_pkg::WORD, '0, '0, -1);
            end
        end

        idle_cycle();
        if (exp_kind.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Some expected data phases were never completed");
            report_fail();
        end
    end

endmodule

// ==== src/ahb_mem_top.sv ====
// Protected AHB3-Lite memory subsystem
// Decoder, RAM slave and its configuration block behind one master port

module ahb_mem_top (
    input  logic                   s_clk_i,
    input  logic                   s_resetn_i,
    input  ahb_mem_pkg::ahb_req_t  req_i,
    input  ahb_mem_pkg::ahb_wdat_t wdat_i,
    output ahb_mem_pkg::ahb_rsp_t  rsp_o
);

    logic                  ram_sel;
    logic                  cfg_sel;
    logic                  hready;
    ahb_mem_pkg::ahb_rsp_t ram_rsp;
    ahb_mem_pkg::ahb_rsp_t cfg_rsp;
    ahb_mem_pkg::wait_t    wait_cnt;
    logic                  par_err;

    ahb_decoder u_decoder (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .req_i      (req_i),
        .ram_rsp_i  (ram_rsp),
        .cfg_rsp_i  (cfg_rsp),
        .ram_sel_o  (ram_sel),
        .cfg_sel_o  (cfg_sel),
        .hready_o   (hready),
        .rsp_o      (rsp_o)
    );

    ahb_ram u_ram (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .sel_i      (ram_sel),
        .hready_i   (hready),
        .req_i      (req_i),
        .wdat_i     (wdat_i),
        .wait_cnt_i (wait_cnt),
        .rsp_o      (ram_rsp),
        .par_err_o  (par_err)
    );

    // Wait states and error count live here
    ahb_ram_cfg u_cfg (
        .s_clk_i    (s_clk_i),
        .s_resetn_i (s_resetn_i),
        .sel_i      (cfg_sel),
        .hready_i   (hready),
        .req_i      (req_i),
        .wdat_i     (wdat_i),
        .par_err_i  (par_err),
        .rsp_o      (cfg_rsp),
        .wait_cnt_o (wait_cnt)
    );

endmodule

// ==== src/ahb_ram_cfg.sv ====
// Configuration slave for the protected RAM
// Holds the wait-state register and a saturating parity-error counter

module ahb_ram_cfg (
    input  logic                   s_clk_i,
    input  logic                   s_resetn_i,
    input  logic                   sel_i,
    input  logic                   hready_i,
    input  ahb_mem_pkg::ahb_req_t  req_i,
    input  ahb_mem_pkg::ahb_wdat_t wdat_i,
    input  logic                   par_err_i,
    output ahb_mem_pkg::ahb_rsp_t  rsp_o,
    output ahb_mem_pkg::wait_t     wait_cnt_o
);

    logic                 active;
    logic                 accept;
    ahb_mem_pkg::addr_t   ofs;
    logic                 is_wait;
    logic                 is_cnt;

    // Data-phase flags
    logic                 dp_write_q;
    logic                 dp_wait_q;
    logic                 dp_cnt_q;

    // Registers
    ahb_mem_pkg::wait_t   wait_q;
    ahb_mem_pkg::errcnt_t cnt_q;
    logic                 cnt_clr;

    assign active  = (req_i.htrans == ahb_mem_pkg::NONSEQ) ||
                     (req_i.htrans == ahb_mem_pkg::SEQ);
    assign accept  = sel_i & active & hready_i;
    assign ofs     = req_i.haddr & ~ahb_mem_pkg::REGION_MASK;
    assign is_wait = (ofs == ahb_mem_pkg::CFG_WAIT_OFS);
    assign is_cnt  = (ofs == ahb_mem_pkg::CFG_ERRCNT_OFS);

    // Any write to the counter clears it
    assign cnt_clr = dp_write_q & dp_cnt_q;

    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            dp_write_q <= 1'b0;
            dp_wait_q  <= 1'b0;
            dp_cnt_q   <= 1'b0;
        end else if (hready_i) begin
            dp_write_q <= accept & req_i.hwrite;
            dp_wait_q  <= accept & is_wait;
            dp_cnt_q   <= accept & is_cnt;
        end
    end

    // Wait register takes the low bits of the write data
    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            wait_q <= '0;
        end else if (dp_write_q && dp_wait_q) begin
            wait_q <= wdat_i.hwdata[1:0];
        end
    end

    // Counter saturates at its maximum
    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            cnt_q <= '0;
        end else if (cnt_clr) begin
            cnt_q <= '0;
        end else if (par_err_i && (cnt_q != '1)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_comb begin
        rsp_o.hrdata = '0;
        if (dp_wait_q) begin
            rsp_o.hrdata[1:0] = wait_q;
        end else if (dp_cnt_q) begin
            rsp_o.hrdata[15:0] = cnt_q;
        end
        rsp_o.hrchecksum = '0;
        rsp_o.hready     = 1'b1;
        rsp_o.hresp      = 1'b0;
    end

    assign wait_cnt_o = wait_q;

    // Saturated counter only returns to zero through a clearing write
    property p_cnt_no_wrap;
        @(posedge s_clk_i) disable iff (!s_resetn_i)
            ((cnt_q == '1) && !cnt_clr) |=> (cnt_q == '1);
    endproperty
    a_cnt_no_wrap: assert property (p_cnt_no_wrap)
        else $error("ahb_ram_cfg: error counter wrapped");

endmodule

// ==== src/ahb_ram.sv ====
// Parity-protected AHB3-Lite RAM slave
// Byte-lane writes, per-word checksum store, write-to-read forwarding
// and a configurable number of wait states

module ahb_ram (
    input  logic                   s_clk_i,
    input  logic                   s_resetn_i,
    input  logic                   sel_i,
    input  logic                   hready_i,
    input  ahb_mem_pkg::ahb_req_t  req_i,
    input  ahb_mem_pkg::ahb_wdat_t wdat_i,
    input  ahb_mem_pkg::wait_t     wait_cnt_i,
    output ahb_mem_pkg::ahb_rsp_t  rsp_o,
    output logic                   par_err_o
);

    // Word and checksum storage
    ahb_mem_pkg::data_t mem_q  [ahb_mem_pkg::MEM_WORDS];
    ahb_mem_pkg::csum_t csum_q [ahb_mem_pkg::MEM_WORDS];

    ahb_mem_pkg::par_t                    par_calc;
    logic                                 active;
    logic                                 accept;
    logic                                 par_err;
    logic [ahb_mem_pkg::WORD_IDX_W-1:0]   req_idx;

    // Address-phase registers
    logic [ahb_mem_pkg::WORD_IDX_W-1:0]   dp_idx_q;
    logic [1:0]                           dp_ofs_q;
    ahb_mem_pkg::hsize_e                  dp_size_q;
    logic                                 dp_write_q;
    ahb_mem_pkg::wait_t                   wait_q;
    ahb_mem_pkg::resp_state_e             state_q;

    // Read path and forwarding
    ahb_mem_pkg::data_t                   rd_data_q;
    ahb_mem_pkg::csum_t                   rd_csum_q;
    logic                                 fwd_hit_q;
    ahb_mem_pkg::data_t                   fwd_data_q;
    ahb_mem_pkg::csum_t                   fwd_csum_q;
    ahb_mem_pkg::data_t                   cur_word;
    ahb_mem_pkg::csum_t                   cur_csum;
    ahb_mem_pkg::data_t                   wr_word;
    logic [3:0]                           lanes;
    logic                                 mem_we;

    // Parity over address bytes, control and transfer type
    assign par_calc[0] = ^req_i.haddr[7:0];
    assign par_calc[1] = ^req_i.haddr[15:8];
    assign par_calc[2] = ^req_i.haddr[23:16];
    assign par_calc[3] = ^req_i.haddr[31:24];
    assign par_calc[4] = ^{req_i.hsize, req_i.hburst, req_i.hprot,
                           req_i.hwrite, req_i.hmastlock};
    assign par_calc[5] = ^req_i.htrans;

    assign active  = (req_i.htrans == ahb_mem_pkg::NONSEQ) ||
                     (req_i.htrans == ahb_mem_pkg::SEQ);
    assign accept  = sel_i & active & hready_i;
    assign par_err = (par_calc != req_i.hparity);
    assign req_idx = req_i.haddr[ahb_mem_pkg::WORD_IDX_W+1:2];

    // Commit on the last data-phase cycle of a clean write
    assign mem_we = dp_write_q && (wait_q == '0);

    always_comb begin
        case (dp_size_q)
            ahb_mem_pkg::BYTE: lanes = 4'b0001 << dp_ofs_q;
            ahb_mem_pkg::HALF: lanes = dp_ofs_q[1] ? 4'b1100 : 4'b0011;
            default:           lanes = 4'b1111;
        endcase
    end

    // Previous write wins over the stale memory read
    assign cur_word = fwd_hit_q ? fwd_data_q : rd_data_q;
    assign cur_csum = fwd_hit_q ? fwd_csum_q : rd_csum_q;

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wr_word[8*b +: 8] = lanes[b] ? wdat_i.hwdata[8*b +: 8] : cur_word[8*b +: 8];
        end
    end

    // Memory write by byte lane, synchronous read in the address phase
    always_ff @(posedge s_clk_i) begin
        if (mem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    mem_q[dp_idx_q][8*b +: 8] <= wdat_i.hwdata[8*b +: 8];
                end
            end
            csum_q[dp_idx_q] <= wdat_i.hwchecksum;
        end
        if (accept) begin
            rd_data_q <= mem_q[req_idx];
            rd_csum_q <= csum_q[req_idx];
        end
    end

    // Payload registers
    always_ff @(posedge s_clk_i) begin
        if (accept) begin
            dp_idx_q  <= req_idx;
            dp_ofs_q  <= req_i.haddr[1:0];
            dp_size_q <= req_i.hsize;
        end
        if (mem_we) begin
            fwd_data_q <= wr_word;
            fwd_csum_q <= wdat_i.hwchecksum;
        end
    end

    // Data-phase control
    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            state_q    <= ahb_mem_pkg::OKAY_ST;
            dp_write_q <= 1'b0;
            wait_q     <= '0;
            fwd_hit_q  <= 1'b0;
        end else if (state_q == ahb_mem_pkg::ERR1_ST) begin
            state_q <= ahb_mem_pkg::ERR2_ST;
        end else if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
        end else if (hready_i) begin
            dp_write_q <= accept & ~par_err & req_i.hwrite;
            wait_q     <= (accept & ~par_err) ? wait_cnt_i : '0;
            state_q    <= (accept & par_err) ? ahb_mem_pkg::ERR1_ST : ahb_mem_pkg::OKAY_ST;
            // Back-to-back access to the word being written now
            fwd_hit_q  <= accept & mem_we & (req_idx == dp_idx_q);
        end
    end

    // Response
    always_comb begin
        rsp_o.hrdata     = cur_word;
        rsp_o.hrchecksum = cur_csum;
        rsp_o.hresp      = (state_q != ahb_mem_pkg::OKAY_ST);
        if (state_q == ahb_mem_pkg::OKAY_ST) begin
            rsp_o.hready = (wait_q == '0);
        end else begin
            rsp_o.hready = (state_q == ahb_mem_pkg::ERR2_ST);
        end
    end

    assign par_err_o = (state_q == ahb_mem_pkg::ERR1_ST);

    // First ERROR cycle must be followed by the completing one
    property p_err_two_cycle;
        @(posedge s_clk_i) disable iff (!s_resetn_i)
            (rsp_o.hresp && !rsp_o.hready) |=> (rsp_o.hresp && rsp_o.hready);
    endproperty
    a_err_two_cycle: assert property (p_err_two_cycle)
        else $error("ahb_ram: ERROR response not completed in second cycle");

    // A rejected transfer never reaches the memory
    property p_no_write_on_err;
        @(posedge s_clk_i) disable iff (!s_resetn_i)
            (state_q != ahb_mem_pkg::OKAY_ST) |-> !mem_we;
    endproperty
    a_no_write_on_err: assert property (p_no_write_on_err)
        else $error("ahb_ram: memory written during parity error response");

endmodule

// ==== src/ahb_decoder.sv ====
// AHB-Lite address decoder and response multiplexer
// Also acts as the default slave for unmapped transfers

module ahb_decoder (
    input  logic                  s_clk_i,
    input  logic                  s_resetn_i,
    input  ahb_mem_pkg::ahb_req_t req_i,
    input  ahb_mem_pkg::ahb_rsp_t ram_rsp_i,
    input  ahb_mem_pkg::ahb_rsp_t cfg_rsp_i,
    output logic                  ram_sel_o,
    output logic                  cfg_sel_o,
    output logic                  hready_o,
    output ahb_mem_pkg::ahb_rsp_t rsp_o
);

    ahb_mem_pkg::addr_t       region;
    logic                     active;
    logic                     unmapped;
    logic                     own_ram_q;
    logic                     own_cfg_q;
    ahb_mem_pkg::resp_state_e state_q;

    assign region    = req_i.haddr & ahb_mem_pkg::REGION_MASK;
    assign ram_sel_o = (region == ahb_mem_pkg::RAM_BASE);
    assign cfg_sel_o = (region == ahb_mem_pkg::CFG_BASE);
    assign active    = (req_i.htrans == ahb_mem_pkg::NONSEQ) ||
                       (req_i.htrans == ahb_mem_pkg::SEQ);
    assign unmapped  = active & ~ram_sel_o & ~cfg_sel_o;

    // Owner of the data phase moves on only when the bus is ready
    always_ff @(posedge s_clk_i) begin
        if (!s_resetn_i) begin
            own_ram_q <= 1'b0;
            own_cfg_q <= 1'b0;
            state_q   <= ahb_mem_pkg::OKAY_ST;
        end else if (state_q == ahb_mem_pkg::ERR1_ST) begin
            state_q <= ahb_mem_pkg::ERR2_ST;
        end else if (hready_o) begin
            own_ram_q <= ram_sel_o & active;
            own_cfg_q <= cfg_sel_o & active;
            state_q   <= unmapped ? ahb_mem_pkg::ERR1_ST : ahb_mem_pkg::OKAY_ST;
        end
    end

    always_comb begin
        if (own_ram_q) begin
            rsp_o = ram_rsp_i;
        end else if (own_cfg_q) begin
            rsp_o = cfg_rsp_i;
        end else begin
            // Default slave
            rsp_o.hrdata     = '0;
            rsp_o.hrchecksum = '0;
            rsp_o.hready     = (state_q != ahb_mem_pkg::ERR1_ST);
            rsp_o.hresp      = (state_q != ahb_mem_pkg::OKAY_ST);
        end
    end

    assign hready_o = rsp_o.hready;

    property p_one_hot_sel;
        @(posedge s_clk_i) disable iff (!s_resetn_i)
            !(ram_sel_o && cfg_sel_o);
    endproperty
    a_one_hot_sel: assert property (p_one_hot_sel)
        else $error("ahb_decoder: both slaves selected");

endmodule

// ==== src/ahb_mem_pkg.sv ====
// Shared definitions for the parity-protected AHB3-Lite memory subsystem
// Widths, address map, bus codes and the request/response structs

package ahb_mem_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [6:0]  csum_t;
    typedef logic [5:0]  par_t;
    typedef logic [1:0]  wait_t;
    typedef logic [15:0] errcnt_t;

    // Memory geometry
    localparam int MEM_BYTES  = 4096;
    localparam int MEM_WORDS  = MEM_BYTES / 4;
    localparam int WORD_IDX_W = 10;

    // Address map
    localparam addr_t RAM_BASE       = 32'h0000_0000;
    localparam addr_t CFG_BASE       = 32'h0001_0000;
    localparam addr_t REGION_MASK    = 32'hFFFF_0000;
    localparam addr_t CFG_WAIT_OFS   = 32'h0000_0000;
    localparam addr_t CFG_ERRCNT_OFS = 32'h0000_0004;

    // Transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // Transfer size, only up to word width
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // Two-cycle ERROR response sequence
    typedef enum logic [1:0] {
        OKAY_ST,
        ERR1_ST,
        ERR2_ST
    } resp_state_e;

    // Address phase, driven by the master
    typedef struct packed {
        addr_t      haddr;
        htrans_e    htrans;
        logic       hwrite;
        hsize_e     hsize;
        logic [2:0] hburst;
        logic [3:0] hprot;
        logic       hmastlock;
        par_t       hparity;
    } ahb_req_t;

    // Data phase write payload
    typedef struct packed {
        data_t hwdata;
        csum_t hwchecksum;
    } ahb_wdat_t;

    // Slave response
    typedef struct packed {
        data_t hrdata;
        csum_t hrchecksum;
        logic  hready;
        logic  hresp;
    } ahb_rsp_t;

endpackage
